// ==== hw/fe_params.svh ====
`ifndef FE_PARAMS_SVH
`define FE_PARAMS_SVH

// host queue word
`define FE_MSG_W 32

// external memory side
`define FE_APP_W 64
`define FE_ADDR_W 27
`define FE_ADDR_INC 8 // one BL8 burst
`define FE_START_ADDR 0

// coefficient blocks are four queue words, written as two beats
`define FE_WORDS_PER_BURST 4

// pixel geometry
`define FE_PIXELS_PER_WORD 4
`define FE_ROW_W 12 // 2048 rows plus dark rows top and bottom
`define FE_COL_W 11
`define FE_FRAME_W 20

// word fields
`define FE_TAG_W 2
`define FE_TAG_PIXEL 2'b00
`define FE_TAG_END 2'b01 // end of coefficients
`define FE_FVAL_BIT 5
`define FE_LVAL_BIT 4

`endif

// ==== hw/fe_pkg.sv ====
`include "fe_params.svh"

package fe_pkg;

  // queue word and its tag field
  typedef logic [`FE_MSG_W-1:0] msg_word_t;
  typedef logic [`FE_TAG_W-1:0] msg_tag_t;

  // memory interface
  typedef logic [`FE_APP_W-1:0] app_data_t;
  typedef logic [`FE_ADDR_W-1:0] app_addr_t;

  // word position inside a coefficient block
  typedef logic [$clog2(`FE_WORDS_PER_BURST)-1:0] blk_pos_t;

  // one full coefficient block, two memory beats wide
  typedef logic [`FE_WORDS_PER_BURST*`FE_MSG_W-1:0] coeff_block_t;

  // frame position counters
  typedef logic [`FE_ROW_W-1:0] row_t;
  typedef logic [`FE_COL_W-1:0] col_t;
  typedef logic [`FE_FRAME_W-1:0] frame_t;

  // coefficient writer states
  typedef enum logic [2:0] {
    COLLECT, // filling the block from the queue
    WR_WAIT, // app_en up, waiting for the controller
    BEAT1, // first beat on the write data bus
    BEAT2, // second beat, app_wdf_end high
    DONE // end tag seen, no more coefficients
  } writer_state_t;

  // line and frame states
  typedef enum logic [1:0] {
    STANDBY,
    INTRALINE,
    INTERLINE,
    INTERFRAME
  } pixel_state_t;

endpackage

// ==== hw/msg_classifier.sv ====
`include "fe_params.svh"

module msg_classifier (
  input  logic              bus_clk,
  input  logic              fds_val,
  input  logic              pc_msg_empty,
  input  fe_pkg::msg_word_t pc_msg,
  output logic              pc_msg_ack,
  input  logic              coeff_ready,
  output logic              word_valid,
  output fe_pkg::msg_word_t word,
  output logic              word_is_pixel
);
  import fe_pkg::*;

  msg_tag_t tag;
  blk_pos_t blk_pos; // coefficient words already taken from the open block
  logic is_pixel;

  assign tag = pc_msg[`FE_TAG_W-1:0];

  // a pixel word can only show up between blocks
  assign is_pixel = (tag == `FE_TAG_PIXEL) && (blk_pos == '0);

  // pixel words always go, coefficient words wait for the writer
  assign pc_msg_ack = !pc_msg_empty && (is_pixel || coeff_ready);

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      blk_pos <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= pc_msg_ack;
      if (pc_msg_ack && !is_pixel) begin
        blk_pos <= blk_pos + 1'b1; // wraps after the fourth word
      end
    end
  end

  // registered copy of the accepted word and its class
  always_ff @(posedge bus_clk) begin
    if (pc_msg_ack) begin
      word <= pc_msg;
      word_is_pixel <= is_pixel;
    end
  end

endmodule

// ==== hw/coeff_burst_writer.sv ====
`include "fe_params.svh"

module coeff_burst_writer (
  input  logic              bus_clk,
  input  logic              fds_val,
  input  logic              word_valid,
  input  logic              word_is_pixel,
  input  fe_pkg::msg_word_t word,
  output logic              coeff_ready,
  input  logic              app_rdy,
  input  logic              app_wdf_rdy,
  output logic              app_en,
  output logic              app_wdf_wren,
  output logic              app_wdf_end,
  output fe_pkg::app_addr_t app_addr,
  output fe_pkg::app_data_t app_wdf_data,
  output logic              coeff_done
);
  import fe_pkg::*;

  localparam blk_pos_t LAST_POS = blk_pos_t'(`FE_WORDS_PER_BURST - 1);

  writer_state_t state;
  blk_pos_t fill_cnt; // words received into the current block
  coeff_block_t block;
  logic end_tag; // fourth word of the block carried the end tag
  logic coeff_write;
  logic blk_last;
  logic beat1_go;
  logic beat2_go;

  assign coeff_write = word_valid && !word_is_pixel;
  assign blk_last = coeff_write && (fill_cnt == LAST_POS);

  // controller takes the command and the first beat together
  assign beat1_go = (state == WR_WAIT) && app_rdy && app_wdf_rdy;
  assign beat2_go = (state == BEAT1) && app_wdf_rdy;

  // drop ready as soon as the closing word lands so no fifth word slips in
  assign coeff_ready = (state == COLLECT) && !blk_last;

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      state <= COLLECT;
      fill_cnt <= '0;
      end_tag <= 1'b0;
      app_en <= 1'b0;
      app_wdf_wren <= 1'b0;
      app_wdf_end <= 1'b1;
      app_addr <= app_addr_t'(`FE_START_ADDR);
      coeff_done <= 1'b0;
    end else begin
      case (state)
        COLLECT: begin
          if (coeff_write) begin
            fill_cnt <= fill_cnt + 1'b1;
            if (blk_last) begin
              end_tag <= (word[`FE_TAG_W-1:0] == `FE_TAG_END);
              app_en <= 1'b1;
              state <= WR_WAIT;
            end
          end
        end
        WR_WAIT: begin
          if (beat1_go) begin
            app_en <= 1'b0;
            app_addr <= app_addr + app_addr_t'(`FE_ADDR_INC); // next burst
            app_wdf_wren <= 1'b1;
            app_wdf_end <= 1'b0;
            state <= BEAT1;
          end
        end
        BEAT1: begin
          if (beat2_go) begin
            app_wdf_end <= 1'b1;
            state <= BEAT2;
          end
        end
        BEAT2: begin
          app_wdf_wren <= 1'b0;
          coeff_done <= end_tag;
          state <= end_tag ? DONE : COLLECT;
        end
        DONE: begin
          state <= DONE; // coefficient stream closed for good
        end
        default: begin
          state <= COLLECT;
        end
      endcase
    end
  end

  // block assembly and beat data
  always_ff @(posedge bus_clk) begin
    if ((state == COLLECT) && coeff_write) begin
      block[fill_cnt*`FE_MSG_W +: `FE_MSG_W] <= word;
    end
    if (beat1_go) begin
      app_wdf_data <= block[0 +: `FE_APP_W]; // words 1 and 0
    end else if (beat2_go) begin
      app_wdf_data <= block[`FE_APP_W +: `FE_APP_W]; // words 3 and 2
    end
  end

endmodule

// ==== hw/frame_position_tracker.sv ====
`include "fe_params.svh"

module frame_position_tracker (
  input  logic              bus_clk,
  input  logic              fds_val,
  input  logic              word_valid,
  input  logic              word_is_pixel,
  input  fe_pkg::msg_word_t word,
  output fe_pkg::row_t      cur_row,
  output fe_pkg::col_t      cur_col,
  output fe_pkg::frame_t    frame_count
);
  import fe_pkg::*;

  pixel_state_t state;
  logic pixel_word;
  logic fval;
  logic lval;

  assign pixel_word = word_valid && word_is_pixel;
  assign fval = word[`FE_FVAL_BIT];
  assign lval = word[`FE_LVAL_BIT];

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      state <= STANDBY;
      cur_row <= '0;
      cur_col <= '0;
      frame_count <= '0;
    end else if (pixel_word) begin
      case (state)
        STANDBY: begin
          // wait for a frame gap before trusting the counters
          if (!fval) begin
            cur_row <= '0;
            cur_col <= '0;
            frame_count <= '0;
            state <= INTERFRAME;
          end
        end
        INTERFRAME: begin
          if (lval) begin // first line of a new frame
            cur_row <= '0;
            cur_col <= '0;
            state <= INTRALINE;
          end
        end
        INTRALINE: begin
          if (lval) begin
            cur_col <= cur_col + col_t'(`FE_PIXELS_PER_WORD);
          end else if (fval) begin
            cur_row <= cur_row + 1'b1; // line ended inside the frame
            state <= INTERLINE;
          end else begin
            frame_count <= frame_count + 1'b1;
            state <= INTERFRAME;
          end
        end
        INTERLINE: begin
          if (lval) begin
            cur_col <= '0;
            state <= INTRALINE;
          end
        end
        default: begin
          state <= STANDBY;
        end
      endcase
    end
  end

endmodule

// ==== hw/camera_msg_frontend.sv ====
module camera_msg_frontend (
  input  logic              bus_clk,
  input  logic              fds_val,
  // host message queue
  input  logic              pc_msg_empty,
  input  fe_pkg::msg_word_t pc_msg,
  output logic              pc_msg_ack,
  // external memory write port
  input  logic              app_rdy,
  input  logic              app_wdf_rdy,
  output logic              app_en,
  output logic              app_wdf_wren,
  output logic              app_wdf_end,
  output fe_pkg::app_addr_t app_addr,
  output fe_pkg::app_data_t app_wdf_data,
  output logic              coeff_done,
  // frame position
  output fe_pkg::row_t      cur_row,
  output fe_pkg::col_t      cur_col,
  output fe_pkg::frame_t    frame_count
);
  import fe_pkg::*;

  logic word_valid;
  logic word_is_pixel;
  logic coeff_ready;
  msg_word_t word;

  msg_classifier u_decode (
    .bus_clk       (bus_clk),
    .fds_val       (fds_val),
    .pc_msg_empty  (pc_msg_empty),
    .pc_msg        (pc_msg),
    .pc_msg_ack    (pc_msg_ack),
    .coeff_ready   (coeff_ready),
    .word_valid    (word_valid),
    .word          (word),
    .word_is_pixel (word_is_pixel)
  );

  coeff_burst_writer u_execute (
    .bus_clk       (bus_clk),
    .fds_val       (fds_val),
    .word_valid    (word_valid),
    .word_is_pixel (word_is_pixel),
    .word          (word),
    .coeff_ready   (coeff_ready),
    .app_rdy       (app_rdy),
    .app_wdf_rdy   (app_wdf_rdy),
    .app_en        (app_en),
    .app_wdf_wren  (app_wdf_wren),
    .app_wdf_end   (app_wdf_end),
    .app_addr      (app_addr),
    .app_wdf_data  (app_wdf_data),
    .coeff_done    (coeff_done)
  );

  frame_position_tracker u_result (
    .bus_clk       (bus_clk),
    .fds_val       (fds_val),
    .word_valid    (word_valid),
    .word_is_pixel (word_is_pixel),
    .word          (word),
    .cur_row       (cur_row),
    .cur_col       (cur_col),
    .frame_count   (frame_count)
  );

endmodule

// ==== verif/camera_msg_frontend_properties.sv ====
module camera_msg_frontend_properties (
  input logic bus_clk,
  input logic fds_val,
  input logic app_en,
  input logic app_wdf_wren,
  input logic app_wdf_end,
  input logic coeff_done
);

  // end strobe idles high and only drops inside a write
  end_low_in_write: assert property (@(posedge bus_clk) disable iff (fds_val)
    !app_wdf_end |-> app_wdf_wren)
    else $error("app_wdf_end low outside a write beat");

  // first beat stays on the bus with no new command until the last beat
  first_beat_then_last: assert property (@(posedge bus_clk) disable iff (fds_val)
    app_wdf_wren && !app_wdf_end |=> app_wdf_wren && !app_en)
    else $error("first beat not followed by the last beat before the next command");

  cmd_not_in_write: assert property (@(posedge bus_clk) disable iff (fds_val)
    app_en |-> !app_wdf_wren)
    else $error("app_en high during a write beat");

  done_sticky: assert property (@(posedge bus_clk) disable iff (fds_val)
    coeff_done |=> coeff_done) // stream closed for good
    else $error("coeff_done fell");

endmodule

bind coeff_burst_writer camera_msg_frontend_properties u_props (.*);

// ==== verif/tb_camera_msg_frontend.sv ====
`include "fe_params.svh"

module tb_camera_msg_frontend;
  import fe_pkg::*;

  localparam int NUM_CYCLES = 4000; // cycles with the queue running
  localparam int TIMEOUT_CYCLES = NUM_CYCLES * 8;
  localparam logic [31:0] LFSR_SEED = 32'hf342fb57;
  localparam logic [31:0] LFSR_TAPS = 32'ha3000000;

  // write phase of the block in flight
  localparam int PH_COLLECT = 0;
  localparam int PH_LAST_WORD = 1; // fourth word sits at the writer input
  localparam int PH_CMD = 2;
  localparam int PH_BEAT1 = 3;
  localparam int PH_BEAT2 = 4;

  logic bus_clk = 1'b0;
  logic fds_val;
  logic pc_msg_empty;
  msg_word_t pc_msg;
  logic pc_msg_ack;
  logic app_rdy;
  logic app_wdf_rdy;
  logic app_en;
  logic app_wdf_wren;
  logic app_wdf_end;
  app_addr_t app_addr;
  app_data_t app_wdf_data;
  logic coeff_done;
  row_t cur_row;
  col_t cur_col;
  frame_t frame_count;

  logic [31:0] lfsr = LFSR_SEED;
  int cycle_cnt = 0;
  logic popped = 1'b0; // head word taken at the coming edge
  logic head_empty = 1'b1;

  // reference model
  int m_blk_pos = 0;
  msg_word_t m_blk [`FE_WORDS_PER_BURST];
  int phase = PH_COLLECT;
  logic pend_end = 1'b0;
  logic m_done = 1'b0;
  app_data_t exp_beat1;
  app_data_t exp_beat2;
  int burst_n = 0;
  pixel_state_t m_pstate = STANDBY;
  row_t m_row = '0;
  col_t m_col = '0;
  frame_t m_frame = '0;
  // counters show up two cycles after the ack
  row_t p1_row = '0;
  col_t p1_col = '0;
  frame_t p1_frame = '0;
  row_t p2_row = '0;
  col_t p2_col = '0;
  frame_t p2_frame = '0;

  camera_msg_frontend u_dut (
    .bus_clk      (bus_clk),
    .fds_val      (fds_val),
    .pc_msg_empty (pc_msg_empty),
    .pc_msg       (pc_msg),
    .pc_msg_ack   (pc_msg_ack),
    .app_rdy      (app_rdy),
    .app_wdf_rdy  (app_wdf_rdy),
    .app_en       (app_en),
    .app_wdf_wren (app_wdf_wren),
    .app_wdf_end  (app_wdf_end),
    .app_addr     (app_addr),
    .app_wdf_data (app_wdf_data),
    .coeff_done   (coeff_done),
    .cur_row      (cur_row),
    .cur_col      (cur_col),
    .frame_count  (frame_count)
  );

  always #50 bus_clk = ~bus_clk;

  task automatic stop_on_error();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic show_mismatch(input string name, input logic [63:0] exp_val,
                               input logic [63:0] act_val);
    $display("MISMATCH %s: expected %0h, actual %0h", name, exp_val, act_val);
    stop_on_error();
  endtask

  task automatic explain_failure(input string reason);
    $display("ERROR: %s", reason);
    stop_on_error();
  endtask

  always @(posedge bus_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_on_error();
    end
  end

  function automatic logic [31:0] galois_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = galois_step(lfsr);
      bits[i] = lfsr[0];
    end
  endtask

  // line and frame rules, applied to the model state
  task automatic apply_pixel_rules(input msg_word_t w);
    logic fval;
    logic lval;
    fval = w[`FE_FVAL_BIT];
    lval = w[`FE_LVAL_BIT];
    case (m_pstate)
      STANDBY: begin
        if (!fval) begin
          m_row = '0;
          m_col = '0;
          m_frame = '0;
          m_pstate = INTERFRAME;
        end
      end
      INTERFRAME: begin
        if (lval) begin
          m_row = '0;
          m_col = '0;
          m_pstate = INTRALINE;
        end
      end
      INTRALINE: begin
        if (lval) begin
          m_col = m_col + col_t'(`FE_PIXELS_PER_WORD);
        end else if (fval) begin
          m_row = m_row + 1'b1;
          m_pstate = INTERLINE;
        end else begin
          m_frame = m_frame + 1'b1;
          m_pstate = INTERFRAME;
        end
      end
      default: begin
        if (lval) begin
          m_col = '0;
          m_pstate = INTRALINE;
        end
      end
    endcase
  endtask

  // everything is sampled half a cycle away from the DUT's edge
  task automatic sample_and_check();
    logic is_pix;
    logic exp_ack;
    app_addr_t exp_addr;
    @(negedge bus_clk);
    is_pix = (pc_msg[`FE_TAG_W-1:0] == `FE_TAG_PIXEL) && (m_blk_pos == 0);
    exp_ack = !pc_msg_empty && (is_pix || (phase == PH_COLLECT && !m_done));
    exp_addr = app_addr_t'(`FE_START_ADDR + `FE_ADDR_INC * burst_n);
    assert (pc_msg_ack === exp_ack) else show_mismatch("queue ack", exp_ack, pc_msg_ack);
    assert (cur_row === p2_row) else show_mismatch("row counter", p2_row, cur_row);
    assert (cur_col === p2_col) else show_mismatch("column counter", p2_col, cur_col);
    assert (frame_count === p2_frame) else show_mismatch("frame counter", p2_frame, frame_count);
    assert (coeff_done === m_done) else show_mismatch("coeff_done", m_done, coeff_done);
    assert (app_en === (phase == PH_CMD))
      else show_mismatch("app_en", phase == PH_CMD, app_en);
    assert (app_wdf_wren === (phase >= PH_BEAT1))
      else show_mismatch("app_wdf_wren", phase >= PH_BEAT1, app_wdf_wren);
    assert (app_wdf_end === (phase != PH_BEAT1))
      else show_mismatch("app_wdf_end", phase != PH_BEAT1, app_wdf_end);
    if (phase == PH_CMD) begin
      assert (app_addr === exp_addr) else show_mismatch("burst address", exp_addr, app_addr);
    end
    if (phase == PH_BEAT1) begin
      assert (app_wdf_data === exp_beat1) else show_mismatch("beat 1", exp_beat1, app_wdf_data);
    end
    if (phase == PH_BEAT2) begin
      assert (app_wdf_data === exp_beat2) else show_mismatch("beat 2", exp_beat2, app_wdf_data);
    end
    // step the write phase on what the memory offers this cycle
    case (phase)
      PH_LAST_WORD: begin
        phase = PH_CMD;
      end
      PH_CMD: begin
        if (app_rdy && app_wdf_rdy) begin
          phase = PH_BEAT1;
        end
      end
      PH_BEAT1: begin
        if (app_wdf_rdy) begin
          phase = PH_BEAT2;
        end
      end
      PH_BEAT2: begin
        phase = PH_COLLECT;
        burst_n++;
        m_done = m_done || pend_end;
      end
    endcase
    p2_row = p1_row;
    p2_col = p1_col;
    p2_frame = p1_frame;
    if (pc_msg_ack && is_pix) begin
      apply_pixel_rules(pc_msg);
    end else if (pc_msg_ack) begin
      m_blk[m_blk_pos] = pc_msg;
      if (m_blk_pos == `FE_WORDS_PER_BURST - 1) begin
        phase = PH_LAST_WORD;
        pend_end = (pc_msg[`FE_TAG_W-1:0] == `FE_TAG_END);
        exp_beat1 = {m_blk[1], m_blk[0]};
        exp_beat2 = {m_blk[3], m_blk[2]};
        m_blk_pos = 0;
      end else begin
        m_blk_pos++;
      end
    end
    p1_row = m_row;
    p1_col = m_col;
    p1_frame = m_frame;
    popped = pc_msg_ack;
    head_empty = pc_msg_empty;
  endtask

  // called right after a rising edge
  task automatic drive_inputs(input int cyc);
    logic [31:0] r;
    msg_word_t w;
    draw_bits(2, r);
    pc_msg_empty <= (r[1:0] == 2'b11);
    if (popped || head_empty) begin // a waiting word may be swapped while the queue is empty
      draw_bits(32, r);
      w = r;
      draw_bits(1, r);
      if (r[0]) begin
        w[`FE_TAG_W-1:0] = `FE_TAG_PIXEL; // more pixel traffic
      end
      if (w[`FE_TAG_W-1:0] == `FE_TAG_END && cyc < NUM_CYCLES / 2) begin
        w[`FE_TAG_W-1:0] = 2'b10; // keep the coefficient stream open early on
      end
      pc_msg <= w;
    end
    draw_bits(1, r);
    app_rdy <= r[0];
    draw_bits(1, r);
    app_wdf_rdy <= r[0];
  endtask

  initial begin
    fds_val = 1'b1;
    pc_msg_empty = 1'b1;
    pc_msg = '0;
    app_rdy = 1'b0;
    app_wdf_rdy = 1'b0;
    repeat (4) @(posedge bus_clk);
    fds_val <= 1'b0;
    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      sample_and_check();
      @(posedge bus_clk);
      drive_inputs(cyc);
    end
    // drain the last burst with the memory always ready
    sample_and_check();
    @(posedge bus_clk);
    pc_msg_empty <= 1'b1;
    app_rdy <= 1'b1;
    app_wdf_rdy <= 1'b1;
    while (phase != PH_COLLECT) begin
      sample_and_check();
      @(posedge bus_clk);
    end
    repeat (4) begin
      sample_and_check();
      @(posedge bus_clk);
    end
    assert (burst_n > 0) else explain_failure("no coefficient burst was written");
    assert (m_done) else explain_failure("end of coefficients was never reached");
    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/fe_pkg.sv
hw/msg_classifier.sv
hw/coeff_burst_writer.sv
hw/frame_position_tracker.sv
hw/camera_msg_frontend.sv
verif/camera_msg_frontend_properties.sv
verif/tb_camera_msg_frontend.sv

// ==== Bender.yml ====
package:
  name: camera_msg_frontend

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/fe_pkg.sv
      - hw/msg_classifier.sv
      - hw/coeff_burst_writer.sv
      - hw/frame_position_tracker.sv
      - hw/camera_msg_frontend.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/camera_msg_frontend_properties.sv
      - verif/tb_camera_msg_frontend.sv
